// ==== Makefile ====
# Verilator build and run of the mdu testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_mdu with Verilator and run it"
	@echo "  clean  remove the Verilator build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_mdu \
		-f filelist.f -o Vtb_mdu
	@out=$$(./obj_dir/Vtb_mdu +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
mdu_pkg.sv
mdu_muler.sv
mdu_diver.sv
mdu.sv
tb_mdu_sva.sv
tb_mdu.sv

// ==== mdu.sv ====
`timescale 1ns/1ps

module mdu (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  flush_i,

    input  mdu_pkg::mdu_i_t       req_i,
    input  mdu_pkg::decode_info_t di_i,
    input  logic                  valid_i,
    output logic                  ready_o,

    output mdu_pkg::mdu_o_t       res_o,
    output mdu_pkg::decode_info_t di_o,
    output mdu_pkg::word_t [1:0]  data_s_o,
    output logic                  valid_o,
    input  logic                  ready_i
);

    mdu_pkg::mdu_o_t       mul_res;
    mdu_pkg::mdu_o_t       div_res;
    logic                  mul_valid;
    logic                  div_valid;
    logic                  mul_ready;
    logic                  div_ready;
    logic                  mul_done;
    logic                  div_done;

    logic                  req_is_mul;
    logic                  q_is_mul;
    logic                  accept;

    logic                  wait_q;
    mdu_pkg::mdu_op_e      op_q;
    mdu_pkg::decode_info_t di_q;
    mdu_pkg::word_t [1:0]  data_s_q;

    mdu_muler muler (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .req_i    (req_i),
        .valid_i  (mul_valid),
        .ready_o  (mul_ready),
        .res_o    (mul_res),
        .valid_o  (mul_done),
        .ready_i  (ready_i)
    );

    mdu_diver diver (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .req_i    (req_i),
        .valid_i  (div_valid),
        .ready_o  (div_ready),
        .res_o    (div_res),
        .valid_o  (div_done),
        .ready_i  (ready_i)
    );

    assign req_is_mul = mdu_pkg::is_mul_op(req_i.op);
    assign q_is_mul   = mdu_pkg::is_mul_op(op_q);

    // Only one request may reach a unit per operation
    assign mul_valid = valid_i & ~wait_q & req_is_mul;
    assign div_valid = valid_i & ~wait_q & ~req_is_mul;

    assign ready_o = ~wait_q & (req_is_mul ? mul_ready : div_ready);
    assign accept  = valid_i & ready_o;

    assign valid_o = q_is_mul ? mul_done : div_done;
    assign res_o   = q_is_mul ? mul_res : div_res;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wait_q   <= 1'b0;
            op_q     <= mdu_pkg::op_mul;
            di_q     <= '0;
            data_s_q <= '0;
        end else if (flush_i) begin
            wait_q   <= 1'b0;
            op_q     <= mdu_pkg::op_mul;
            di_q     <= '0;
            data_s_q <= '0;
        end else if (accept) begin
            wait_q   <= 1'b1;
            op_q     <= req_i.op;
            di_q     <= di_i;
            data_s_q <= req_i.data;
        end else if (valid_o && ready_i) begin
            wait_q <= 1'b0;  // Response handed off
        end
    end

    assign di_o     = di_q;
    assign data_s_o = data_s_q;

endmodule

// ==== mdu_diver.sv ====
`timescale 1ns/1ps

module mdu_diver (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            flush_i,

    input  mdu_pkg::mdu_i_t req_i,
    input  logic            valid_i,
    output logic            ready_o,

    output mdu_pkg::mdu_o_t res_o,
    output logic            valid_o,
    input  logic            ready_i
);

    localparam logic [2:0] st_idle  = 3'd0;
    localparam logic [2:0] st_iter  = 3'd2;
    localparam logic [2:0] st_fix   = 3'd3;
    localparam logic [2:0] st_done  = 3'd4;

    logic [2:0]       state_q;
    logic [4:0]       cnt_q;

    // Raw request
    mdu_pkg::mdu_op_e op_q;
    mdu_pkg::word_t   a_q;

    // Working registers
    mdu_pkg::word_t   quo_q;
    mdu_pkg::word_t   rem_q;
    mdu_pkg::word_t   dvs_q;
    logic             q_neg_q;
    logic             r_neg_q;
    logic             zero_q;
    logic             ovf_q;
    mdu_pkg::mdu_o_t  res_q;

    logic             accept;
    logic             op_signed;
    logic             op_rem;
    logic             a_neg;
    logic             b_neg;
    mdu_pkg::word_t   abs_a;
    mdu_pkg::word_t   abs_b;
    logic [32:0]      rem_sh;
    logic [32:0]      rem_diff;
    logic             rem_ge;
    mdu_pkg::word_t   quo_fix;
    mdu_pkg::word_t   rem_fix;

    assign ready_o = (state_q == st_idle);
    assign valid_o = (state_q == st_done);
    assign accept  = valid_i & ready_o;

    assign op_signed = (req_i.op == mdu_pkg::op_div) || (req_i.op == mdu_pkg::op_mod);
    assign op_rem    = (op_q == mdu_pkg::op_mod) || (op_q == mdu_pkg::op_modu);

    // Setup is done in the accept cycle
    assign a_neg = op_signed & req_i.data[0][31];
    assign b_neg = op_signed & req_i.data[1][31];
    assign abs_a = a_neg ? -req_i.data[0] : req_i.data[0];
    assign abs_b = b_neg ? -req_i.data[1] : req_i.data[1];

    // One restoring step
    assign rem_sh   = {rem_q, quo_q[31]};
    assign rem_diff = rem_sh - {1'b0, dvs_q};
    assign rem_ge   = (rem_sh >= {1'b0, dvs_q});

    always_comb begin
        if (zero_q) begin
            quo_fix = '1;
            rem_fix = a_q;
        end else if (ovf_q) begin
            quo_fix = a_q;
            rem_fix = '0;
        end else begin
            quo_fix = q_neg_q ? -quo_q : quo_q;
            rem_fix = r_neg_q ? -rem_q : rem_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= st_idle;
            cnt_q   <= '0;
        end else if (flush_i) begin
            state_q <= st_idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (accept) begin
                        state_q <= st_iter;
                        cnt_q   <= '0;
                    end
                end
                st_iter: begin
                    cnt_q <= cnt_q + 5'd1;
                    if (cnt_q == 5'd31) begin  // 32nd step
                        state_q <= st_fix;
                    end
                end
                st_fix: begin
                    state_q <= st_done;
                end
                st_done: begin
                    if (ready_i) begin
                        state_q <= st_idle;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= req_i.op;
            a_q     <= req_i.data[0];
            quo_q   <= abs_a;
            rem_q   <= '0;
            dvs_q   <= abs_b;
            q_neg_q <= a_neg ^ b_neg;
            r_neg_q <= a_neg;
            zero_q  <= (req_i.data[1] == '0);
            ovf_q   <= op_signed && (req_i.data[0] == 32'h8000_0000)
                       && (req_i.data[1] == '1);
        end
        if (state_q == st_iter) begin
            quo_q <= {quo_q[30:0], rem_ge};
            rem_q <= rem_ge ? rem_diff[31:0] : rem_sh[31:0];
        end
        if (state_q == st_fix) begin
            res_q.result <= op_rem ? rem_fix : quo_fix;
        end
    end

    assign res_o = res_q;

endmodule

// ==== mdu_muler.sv ====
`timescale 1ns/1ps

module mdu_muler (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            flush_i,

    input  mdu_pkg::mdu_i_t req_i,
    input  logic            valid_i,
    output logic            ready_o,

    output mdu_pkg::mdu_o_t res_o,
    output logic            valid_o,
    input  logic            ready_i
);

    // Stage 1 holds extended operands
    logic             s1_valid;
    mdu_pkg::mdu_op_e s1_op;
    logic [32:0]      s1_a;
    logic [32:0]      s1_b;

    // Stage 2 holds the selected word
    logic             s2_valid;
    mdu_pkg::mdu_o_t  s2_res;

    logic             s2_ready;
    logic             accept;
    logic             ext_signed;
    logic [65:0]      product;

    assign s2_ready   = ~s2_valid | ready_i;
    assign ready_o    = s2_ready;              // Low while output is held
    assign accept     = valid_i & ready_o;
    assign ext_signed = (req_i.op != mdu_pkg::op_mulhu);

    assign product = $signed(s1_a) * $signed(s1_b);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (flush_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s2_ready) begin
                s1_valid <= accept;
                s2_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_op <= req_i.op;
            s1_a  <= {ext_signed & req_i.data[0][31], req_i.data[0]};
            s1_b  <= {ext_signed & req_i.data[1][31], req_i.data[1]};
        end
    end

    always_ff @(posedge clk) begin
        if (s2_ready && s1_valid) begin
            if (s1_op == mdu_pkg::op_mul) begin
                s2_res.result <= product[31:0];
            end else begin
                s2_res.result <= product[63:32];
            end
        end
    end

    assign res_o   = s2_res;
    assign valid_o = s2_valid;

endmodule

// ==== mdu_pkg.sv ====
package mdu_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [2:0] {
        op_mul   = 3'd0,  // Low word of product
        op_mulh  = 3'd1,  // High word, signed
        op_mulhu = 3'd2,  // High word, unsigned
        op_div   = 3'd3,
        op_divu  = 3'd4,
        op_mod   = 3'd5,
        op_modu  = 3'd6
    } mdu_op_e;

    typedef struct packed {
        mdu_op_e    op;
        word_t [1:0] data;  // Element 0 is rj, element 1 is rk
    } mdu_i_t;

    typedef struct packed {
        word_t result;
    } mdu_o_t;

    typedef struct packed {
        logic       wreg;   // Writes a register
        logic [4:0] wdest;  // Destination register
    } decode_info_t;

    function automatic logic is_mul_op(input mdu_op_e op);
        logic hit;
        hit = (op == op_mul) || (op == op_mulh) || (op == op_mulhu);
        return hit;
    endfunction

endpackage

// ==== tb_mdu.sv ====
`timescale 1ns/1ps

module tb_mdu;

    localparam int num_rand   = 200;
    localparam int num_dir    = 8 * 7;
    localparam int num_ops    = num_dir + num_rand + 3;  // Plus aborted ops
    localparam int timeout_ns = (num_ops * 40 + 200) * 4;

    typedef struct packed {
        int                    idx;
        mdu_pkg::mdu_op_e      op;
        mdu_pkg::word_t        res;
        mdu_pkg::decode_info_t di;
        mdu_pkg::word_t [1:0]  data;
    } expect_t;

    logic                  clk = 1'b0;
    logic                  arst_n_i;
    logic                  flush_i;
    mdu_pkg::mdu_i_t       req_i;
    mdu_pkg::decode_info_t di_i;
    logic                  valid_i;
    logic                  ready_o;
    mdu_pkg::mdu_o_t       res_o;
    mdu_pkg::decode_info_t di_o;
    mdu_pkg::word_t [1:0]  data_s_o;
    logic                  valid_o;
    logic                  ready_i;

    expect_t exp_q[$];
    int      op_count = 0;

    mdu uut (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .req_i    (req_i),
        .di_i     (di_i),
        .valid_i  (valid_i),
        .ready_o  (ready_o),
        .res_o    (res_o),
        .di_o     (di_o),
        .data_s_o (data_s_o),
        .valid_o  (valid_o),
        .ready_i  (ready_i)
    );

    bind mdu mdu_sva sva_chk (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .req_i    (req_i),
        .valid_i  (valid_i),
        .ready_o  (ready_o),
        .res_o    (res_o),
        .di_o     (di_o),
        .data_s_o (data_s_o),
        .valid_o  (valid_o),
        .ready_i  (ready_i)
    );

    always #2 clk = ~clk;

    function automatic string op_name(input mdu_pkg::mdu_op_e op);
        case (op)
            mdu_pkg::op_mul:   return "mul.w";
            mdu_pkg::op_mulh:  return "mulh.w";
            mdu_pkg::op_mulhu: return "mulh.wu";
            mdu_pkg::op_div:   return "div.w";
            mdu_pkg::op_divu:  return "div.wu";
            mdu_pkg::op_mod:   return "mod.w";
            default:           return "mod.wu";
        endcase
    endfunction

    // Reference results from the ISA rules
    function automatic mdu_pkg::word_t model(input mdu_pkg::mdu_op_e op,
                                             input mdu_pkg::word_t a,
                                             input mdu_pkg::word_t b);
        logic signed [63:0] sp;
        logic        [63:0] up;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [31:0] sq;
        logic signed [31:0] sr;
        logic               zero;
        logic               ovf;
        sp   = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        up   = {32'b0, a} * {32'b0, b};
        sa   = a;
        sb   = b;
        sq   = '0;
        sr   = '0;
        zero = (b == '0);
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        if (!zero && !ovf) begin
            sq = sa / sb;  // Truncates toward zero
            sr = sa % sb;
        end
        if (mdu_pkg::is_mul_op(op)) begin
            if (op == mdu_pkg::op_mul) return up[31:0];
            if (op == mdu_pkg::op_mulh) return sp[63:32];
            return up[63:32];
        end
        case (op)
            mdu_pkg::op_div:  return zero ? 32'hffff_ffff : (ovf ? a : sq);
            mdu_pkg::op_divu: return zero ? 32'hffff_ffff : a / b;
            mdu_pkg::op_mod:  return zero ? a : (ovf ? 32'h0 : sr);
            default:          return zero ? a : a % b;
        endcase
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input mdu_pkg::word_t exp,
                                   input mdu_pkg::word_t act);
        stop_run($sformatf("Mismatch test=%s expected=%h actual=%h", test, exp, act));
    endtask

    task automatic check_response();
        expect_t e;
        string   name;
        if (exp_q.size() == 0) begin
            stop_run("A response arrived with no request pending");
        end else begin
            e = exp_q.pop_front();
            name = $sformatf("%s #%0d", op_name(e.op), e.idx);
            assert (res_o.result == e.res)
                else report_mismatch({name, " result"}, e.res, res_o.result);
            assert (di_o == e.di)
                else report_mismatch({name, " tag"}, {26'b0, e.di}, {26'b0, di_o});
            assert (data_s_o[0] == e.data[0])
                else report_mismatch({name, " operand 0"}, e.data[0], data_s_o[0]);
            assert (data_s_o[1] == e.data[1])
                else report_mismatch({name, " operand 1"}, e.data[1], data_s_o[1]);
        end
    endtask

    // Abort 0 runs to completion, 1 flushes and 2 resets abort_wait cycles after acceptance
    task automatic drive_op(input mdu_pkg::mdu_op_e op, input mdu_pkg::word_t a,
                            input mdu_pkg::word_t b, input int abort, input int abort_wait);
        mdu_pkg::mdu_i_t       req;
        mdu_pkg::decode_info_t tag;
        expect_t               e;
        logic [31:0]           rnd;
        rnd          = $urandom;
        req.op       = op;
        req.data[0]  = a;
        req.data[1]  = b;
        tag.wreg     = rnd[5];
        tag.wdest    = rnd[4:0];
        @(posedge clk);
        req_i   <= req;
        di_i    <= tag;
        valid_i <= 1'b1;
        @(negedge clk);
        while (!ready_o) @(negedge clk);
        @(posedge clk);  // Accepted here
        valid_i <= 1'b0;
        if (abort == 0) begin
            e.idx  = op_count;
            e.op   = op;
            e.res  = model(op, a, b);
            e.di   = tag;
            e.data = req.data;
            exp_q.push_back(e);
        end else begin
            repeat (abort_wait) @(posedge clk);
            if (abort == 1) begin
                flush_i <= 1'b1;
                @(posedge clk);
                flush_i <= 1'b0;
            end else begin
                arst_n_i <= 1'b0;
                repeat (2) @(posedge clk);
                arst_n_i <= 1'b1;
            end
        end
        op_count++;
    endtask

    // Response checks and protocol flags sampled mid-cycle
    always @(negedge clk) begin
        if (uut.sva_chk.any_fail) begin
            stop_run("A protocol assertion in mdu_sva failed");
        end else if (arst_n_i && !flush_i && valid_o && ready_i) begin
            check_response();
        end
    end

    initial begin
        ready_i = 1'b0;
        forever begin
            @(posedge clk);
            ready_i <= ($urandom_range(3) != 0);  // Random stall stretches
        end
    end

    initial begin
        #(timeout_ns);
        stop_run("Timeout: the simulation did not finish in the expected time");
    end

    initial begin
        mdu_pkg::word_t dir_a [8];
        mdu_pkg::word_t dir_b [8];
        mdu_pkg::word_t a;
        mdu_pkg::word_t b;
        logic [31:0]    rnd;
        void'($urandom(88));
        arst_n_i = 1'b1;
        flush_i  = 1'b0;
        valid_i  = 1'b0;
        req_i    = '0;
        di_i     = '0;
        dir_a = '{32'h8000_0000, 32'h1234_5678, 32'hffff_fff9, 32'h0000_0007,
                  32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000, 32'h0000_0000};
        dir_b = '{32'hffff_ffff, 32'h0000_0000, 32'h0000_0002, 32'hffff_fffe,
                  32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000, 32'h0000_0005};
        @(posedge clk);
        arst_n_i <= 1'b0;
        repeat (2) @(posedge clk);
        arst_n_i <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 7; k++) begin
                drive_op(mdu_pkg::mdu_op_e'(k[2:0]), dir_a[i], dir_b[i], 0, 0);
            end
        end
        drive_op(mdu_pkg::op_div, 32'd1000, 32'd7, 1, 10);    // Flush mid divide
        drive_op(mdu_pkg::op_mulh, 32'hdead_beef, 32'd3, 1, 0);
        drive_op(mdu_pkg::op_mod, 32'hffff_ff00, 32'd9, 2, 10);  // Reset mid divide
        for (int i = 0; i < num_rand; i++) begin
            rnd = $urandom_range(6);
            a   = $urandom;
            b   = $urandom;
            if ($urandom_range(3) == 0) begin
                b = $urandom_range(15);
            end
            if ($urandom_range(7) == 0) begin
                b = -b;
            end
            drive_op(mdu_pkg::mdu_op_e'(rnd[2:0]), a, b, 0, 0);
        end
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        if (uut.sva_chk.any_fail) begin
            stop_run("Protocol assertion failures were recorded");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== tb_mdu_sva.sv ====
`timescale 1ns/1ps

module mdu_sva (
    input logic                  clk,
    input logic                  arst_n_i,
    input logic                  flush_i,
    input mdu_pkg::mdu_i_t       req_i,
    input logic                  valid_i,
    input logic                  ready_o,
    input mdu_pkg::mdu_o_t       res_o,
    input mdu_pkg::decode_info_t di_o,
    input mdu_pkg::word_t [1:0]  data_s_o,
    input logic                  valid_o,
    input logic                  ready_i
);

    logic       pend_q;
    logic       mul_q;
    logic [5:0] lat_q;
    logic       any_fail;

    bit lat_fail    = 1'b0;
    bit hold_fail   = 1'b0;
    bit single_fail = 1'b0;
    bit spur_fail   = 1'b0;
    bit flush_fail  = 1'b0;
    bit reset_fail  = 1'b0;

    assign any_fail = lat_fail | hold_fail | single_fail | spur_fail | flush_fail | reset_fail;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_q <= 1'b0;
            mul_q  <= 1'b0;
            lat_q  <= '0;
        end else if (flush_i) begin
            pend_q <= 1'b0;
            lat_q  <= '0;
        end else if (valid_i && ready_o) begin
            pend_q <= 1'b1;
            mul_q  <= mdu_pkg::is_mul_op(req_i.op);
            lat_q  <= 6'd1;
        end else if (valid_o && ready_i) begin
            pend_q <= 1'b0;
        end else if (pend_q && !valid_o) begin
            lat_q <= lat_q + 6'd1;  // Cycles since acceptance
        end
    end

    a_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(valid_o) |-> (lat_q == (mul_q ? 6'd2 : 6'd34)))
        else begin
            $error("response came %0d cycles after acceptance", lat_q);
            lat_fail = 1'b1;
        end

    a_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_o && !ready_i && !flush_i |=>
            valid_o && $stable(res_o) && $stable(di_o) && $stable(data_s_o))
        else begin
            $error("response changed while stalled");
            hold_fail = 1'b1;
        end

    a_single: assert property (@(posedge clk) disable iff (!arst_n_i)
        pend_q |-> !ready_o)
        else begin
            $error("ready_o high with an operation in flight");
            single_fail = 1'b1;
        end

    a_no_spurious: assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_o |-> pend_q)
        else begin
            $error("valid_o high with nothing accepted");
            spur_fail = 1'b1;
        end

    a_flush: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |=> !valid_o && ready_o)
        else begin
            $error("unit not idle after flush");
            flush_fail = 1'b1;
        end

    a_reset: assert property (@(posedge clk)
        !arst_n_i |-> !valid_o && ready_o && (di_o == '0) && (data_s_o == '0))
        else begin
            $error("outputs not cleared by reset");
            reset_fail = 1'b1;
        end

endmodule
